//--- Makefile
SIM  := obj_dir/Vbranch_unit_tb
SRCS := $(shell grep -v '^+' compile.f) include/rv32i_encoding.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
		--top-module branch_unit_tb -o Vbranch_unit_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf obj_dir

//--- compile.f
+incdir+include
rtl/branch_pkg.sv
rtl/branch_result_if.sv
rtl/target_address_generator.sv
rtl/branch_resolve_stage.sv
rtl/branch_csr_apb.sv
rtl/branch_unit_top.sv
verif/branch_unit_tb.sv

//--- include/rv32i_encoding.svh
// one-hot 9-bit decoded classes as the decoder emits them; func3 values follow the rv32i spec
`ifndef RV32I_ENCODING_SVH
`define RV32I_ENCODING_SVH

// decoded instruction classes, one bit each
// --------------------
`define ENCODING_LUI      9'b0_0000_0001
`define ENCODING_AUIPC    9'b0_0000_0010
`define ENCODING_JAL      9'b0_0000_0100  // pc relative jump
`define ENCODING_JALR     9'b0_0000_1000  // register relative jump
`define ENCODING_BRANCH   9'b0_0001_0000  // conditional branch, variant in func3
`define ENCODING_LOAD     9'b0_0010_0000
`define ENCODING_STORE    9'b0_0100_0000
`define ENCODING_OP_IMM   9'b0_1000_0000
`define ENCODING_OP       9'b1_0000_0000

// branch func3 values
// --------------------
`define RV32I_FUNC3_BRANCH_BEQ   3'b000
`define RV32I_FUNC3_BRANCH_BNE   3'b001
`define RV32I_FUNC3_BRANCH_BLT   3'b100  // signed
`define RV32I_FUNC3_BRANCH_BGE   3'b101  // signed
`define RV32I_FUNC3_BRANCH_BLTU  3'b110
`define RV32I_FUNC3_BRANCH_BGEU  3'b111
// 3'b010 and 3'b011 are reserved for branches

`endif

//--- rtl/branch_csr_apb.sv
// apb3 slave with pready tied high; unmapped offsets answer pslverr and trap address writes are ignored
`timescale 1ns/1ps

module branch_csr_apb (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  branch_pkg::apb_addr_t paddr_i,
	input  branch_pkg::xlen_t     pwdata_i,
	output branch_pkg::xlen_t     prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	output branch_pkg::exc_t      exc_enable_o,
	input  logic                  redirect_event_i,  // one pulse per redirect
	input  logic                  trap_event_i,      // one pulse per trap
	input  branch_pkg::exc_t      trap_cause_i,
	input  branch_pkg::addr_t     trap_pc_i
);

	branch_pkg::exc_t  ctrl_q;
	branch_pkg::exc_t  status_q;
	branch_pkg::xlen_t count_q;
	branch_pkg::addr_t trap_addr_q;
	logic              access;     // second apb cycle
	logic              wr_en;
	logic              sel_ctrl;
	logic              sel_status;
	logic              sel_count;
	logic              sel_trap;
	branch_pkg::exc_t  status_clr;  // w1c mask
	branch_pkg::exc_t  status_set;  // hardware set

	// address decode
	// --------------------
	assign access     = psel_i && penable_i;
	assign wr_en      = access && pwrite_i;  // lands on the edge ending the access phase
	assign sel_ctrl   = (paddr_i == branch_pkg::REG_CTRL);
	assign sel_status = (paddr_i == branch_pkg::REG_STATUS);
	assign sel_count  = (paddr_i == branch_pkg::REG_REDIRECT_COUNT);
	assign sel_trap   = (paddr_i == branch_pkg::REG_TRAP_ADDR);

	assign pready_o  = 1'b1;  // no wait states
	assign pslverr_o = access && !(sel_ctrl || sel_status || sel_count || sel_trap);

	// registers
	// --------------------
	assign status_clr = (wr_en && sel_status) ? pwdata_i[3:0] : '0;
	assign status_set = trap_event_i ? trap_cause_i : '0;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ctrl_q      <= branch_pkg::CTRL_RESET;
			status_q    <= branch_pkg::STATUS_RESET;
			count_q     <= branch_pkg::REDIRECT_COUNT_RESET;
			trap_addr_q <= branch_pkg::TRAP_ADDR_RESET;
		end else begin
			if (wr_en && sel_ctrl) begin
				ctrl_q <= pwdata_i[3:0];  // upper bits ignored
			end
			status_q <= (status_q & ~status_clr) | status_set;  // set beats clear
			if (wr_en && sel_count) begin
				count_q <= branch_pkg::REDIRECT_COUNT_RESET;  // any write clears
			end else if (redirect_event_i && (count_q != '1)) begin
				count_q <= count_q + 32'd1;  // saturates at all ones
			end
			if (trap_event_i) begin
				trap_addr_q <= trap_pc_i;  // last trap only
			end
		end
	end

	assign exc_enable_o = ctrl_q;

	// read mux returns zero for unmapped offsets
	always_comb begin
		prdata_o = '0;
		if (sel_ctrl)   prdata_o = {28'd0, ctrl_q};
		if (sel_status) prdata_o = {28'd0, status_q};
		if (sel_count)  prdata_o = count_q;
		if (sel_trap)   prdata_o = trap_addr_q;
	end

	// the access phase always follows a selected setup phase
	penable_needs_psel_a: assert property (@(posedge clk_i) disable iff (reset_i)
		penable_i |-> psel_i);

endmodule

//--- rtl/branch_pkg.sv
// widths fixed by rv32i; exception bit positions and apb offsets must match software's view
package branch_pkg;

	// widths
	// --------------------
	typedef logic [31:0] xlen_t;        // operand / data word
	typedef logic [31:0] addr_t;        // byte address of an instruction
	typedef logic [8:0]  encoding_t;    // decoded instruction class, see rv32i_encoding.svh
	typedef logic [2:0]  func3_t;       // branch variant field
	typedef logic [3:0]  exc_t;         // exception vector, one bit per cause
	typedef logic [7:0]  apb_addr_t;    // apb register offset

	// exception bit positions inside exc_t
	// --------------------
	localparam int EXC_FUNC3          = 3;  // branch with func3 outside the six known
	localparam int EXC_MISPREDICT     = 2;  // fetch placed the wrong next address
	localparam int EXC_WORD_MISALIGN  = 1;  // target bit 1 set
	localparam int EXC_HWORD_MISALIGN = 0;  // target bit 0 set

	// address arithmetic
	// --------------------
	localparam addr_t INSTR_BYTES      = 32'd4;          // no compressed instructions here
	localparam addr_t JALR_TARGET_MASK = 32'hffff_fffe;  // isa clears bit 0 of a jalr target

	// apb register map
	// --------------------
	localparam apb_addr_t REG_CTRL           = 8'h00;  // rw, bit n enables exception bit n
	localparam apb_addr_t REG_STATUS         = 8'h04;  // sticky causes, write one to clear
	localparam apb_addr_t REG_REDIRECT_COUNT = 8'h08;  // ro, any write clears
	localparam apb_addr_t REG_TRAP_ADDR      = 8'h0c;  // ro, pc of the last trap

	// register reset values
	// --------------------
	localparam exc_t  CTRL_RESET           = 4'hf;   // every exception enabled out of reset
	localparam exc_t  STATUS_RESET         = 4'h0;
	localparam xlen_t REDIRECT_COUNT_RESET = 32'd0;
	localparam addr_t TRAP_ADDR_RESET      = 32'd0;

endpackage

//--- rtl/branch_resolve_stage.sv
// one result per cycle, no stall; outputs appear exactly one cycle after the result
`timescale 1ns/1ps

module branch_resolve_stage (
	input  logic              clk_i,
	input  logic              reset_i,
	branch_result_if.sink     res,
	input  branch_pkg::exc_t  exc_enable_i,      // from ctrl register
	output logic              redirect_valid_o,  // one-cycle pulse to fetch
	output branch_pkg::addr_t redirect_addr_o,
	output logic              link_valid_o,      // writeback request for jal/jalr
	output branch_pkg::xlen_t link_o,
	output logic              trap_o,            // one-cycle pulse
	output branch_pkg::exc_t  trap_cause_o,      // masked cause, zero when no trap
	output branch_pkg::addr_t trap_pc_o
);

	branch_pkg::exc_t masked;     // causes that software has enabled
	branch_pkg::exc_t trap_bits;  // enabled causes that trap
	logic             trap_hit;
	logic             redirect_hit;
	logic             link_hit;

	// decision
	// --------------------
	always_comb begin
		masked    = res.exc & exc_enable_i;
		trap_bits = masked;
		trap_bits[branch_pkg::EXC_MISPREDICT] = 1'b0;  // mispredict redirects, never traps
	end

	assign trap_hit     = res.valid && (|trap_bits);
	assign redirect_hit = res.valid && !trap_hit
		&& masked[branch_pkg::EXC_MISPREDICT];  // trap wins over redirect
	assign link_hit     = res.valid && res.jump && res.linked && !trap_hit;

	// control flops
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			redirect_valid_o <= 1'b0;
			link_valid_o     <= 1'b0;
			trap_o           <= 1'b0;
			trap_cause_o     <= '0;
		end else begin
			redirect_valid_o <= redirect_hit;
			link_valid_o     <= link_hit;
			trap_o           <= trap_hit;
			trap_cause_o     <= trap_hit ? masked : '0;  // includes mispredict bit if set
		end
	end

	// payload flops, qualified by the control bits above
	always_ff @(posedge clk_i) begin
		redirect_addr_o <= res.target;
		link_o          <= res.link;
		trap_pc_o       <= res.pc;
	end

	// trap and redirect are exclusive per instruction, and one instruction per cycle
	trap_redirect_excl_a: assert property (@(posedge clk_i)
		!(trap_o && redirect_valid_o));

	// no stale pulse may leak past reset into fetch or the csr block
	reset_quiet_a: assert property (@(posedge clk_i)
		reset_i |=> (!trap_o && !redirect_valid_o));

endmodule

//--- rtl/branch_result_if.sv
// there is no handshake so the sink must consume every cycle in which valid is high
`timescale 1ns/1ps

interface branch_result_if;

	logic                 valid;   // instruction present this cycle
	logic                 jump;    // jal, jalr or known branch and only meaningful with valid
	logic                 linked;  // jal or jalr whose link carries a writeback value
	branch_pkg::addr_t    target;  // resolved next pc of the instruction
	branch_pkg::addr_t    link;    // pc + 4 for jumps and zero for branches
	branch_pkg::exc_t     exc;     // raw exception vector before masking
	branch_pkg::addr_t    pc;      // address of the instruction itself

	// generator side
	modport source (
		output valid, jump, linked, target, link, exc, pc
	);

	// resolve stage side
	modport sink (
		input valid, jump, linked, target, link, exc, pc
	);

endinterface

//--- rtl/branch_unit_top.sv
// rv32i branch resolution, one instruction per cycle, results one cycle after valid_i
`timescale 1ns/1ps

module branch_unit_top (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  valid_i,
	input  branch_pkg::encoding_t encoding_i,
	input  branch_pkg::func3_t    func3_i,
	input  branch_pkg::addr_t     instruction_addr_i,
	input  branch_pkg::addr_t     instruction_next_addr_i,
	input  branch_pkg::xlen_t     src1_operand_i,
	input  branch_pkg::xlen_t     src2_operand_i,
	input  branch_pkg::xlen_t     immediate_i,
	// apb
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  branch_pkg::apb_addr_t paddr_i,
	input  branch_pkg::xlen_t     pwdata_i,
	output branch_pkg::xlen_t     prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	// resolved outputs
	output logic                  redirect_valid_o,
	output branch_pkg::addr_t     redirect_addr_o,
	output logic                  link_valid_o,
	output branch_pkg::xlen_t     link_o,
	output logic                  trap_o,
	output branch_pkg::exc_t      trap_cause_o
);

	branch_result_if   res ();  // generator to stage
	branch_pkg::exc_t  exc_enable;
	branch_pkg::addr_t trap_pc;

	target_address_generator u_gen (
		.encoding_i              (encoding_i),
		.instruction_addr_i      (instruction_addr_i),
		.instruction_next_addr_i (instruction_next_addr_i),
		.func3_i                 (func3_i),
		.src1_operand_i          (src1_operand_i),
		.src2_operand_i          (src2_operand_i),
		.immediate_i             (immediate_i),
		.valid_i                 (valid_i),
		.res                     (res.source)
	);

	branch_resolve_stage u_stage (
		.clk_i            (clk_i),
		.reset_i          (reset_i),
		.res              (res.sink),
		.exc_enable_i     (exc_enable),
		.redirect_valid_o (redirect_valid_o),
		.redirect_addr_o  (redirect_addr_o),
		.link_valid_o     (link_valid_o),
		.link_o           (link_o),
		.trap_o           (trap_o),
		.trap_cause_o     (trap_cause_o),
		.trap_pc_o        (trap_pc)
	);

	branch_csr_apb u_csr (
		.clk_i            (clk_i),
		.reset_i          (reset_i),
		.psel_i           (psel_i),
		.penable_i        (penable_i),
		.pwrite_i         (pwrite_i),
		.paddr_i          (paddr_i),
		.pwdata_i         (pwdata_i),
		.prdata_o         (prdata_o),
		.pready_o         (pready_o),
		.pslverr_o        (pslverr_o),
		.exc_enable_o     (exc_enable),
		.redirect_event_i (redirect_valid_o),  // stage pulses feed the counters
		.trap_event_i     (trap_o),
		.trap_cause_i     (trap_cause_o),
		.trap_pc_i        (trap_pc)
	);

endmodule

//--- rtl/target_address_generator.sv
// purely combinational, rv32i only (no compressed), so both misalignment bits are reported
`timescale 1ns/1ps
`include "rv32i_encoding.svh"

module target_address_generator (
	input  branch_pkg::encoding_t encoding_i,
	input  branch_pkg::addr_t     instruction_addr_i,       // pc of the instruction
	input  branch_pkg::addr_t     instruction_next_addr_i,  // pc fetch already sent down the pipe
	input  branch_pkg::func3_t    func3_i,
	input  branch_pkg::xlen_t     src1_operand_i,
	input  branch_pkg::xlen_t     src2_operand_i,
	input  branch_pkg::xlen_t     immediate_i,              // already a byte offset
	input  logic                  valid_i,
	branch_result_if.source       res
);

	branch_pkg::addr_t pc_plus_imm;  // jal and taken branch target
	branch_pkg::addr_t pc_plus_4;    // link and fall-through
	branch_pkg::addr_t reg_target;   // jalr target before bit 0 clear
	logic              jump;
	logic              linked;
	logic              taken;        // branch comparison result
	logic              func3_bad;    // branch variant unknown
	branch_pkg::addr_t target;
	branch_pkg::addr_t link;
	branch_pkg::exc_t  exc;

	// shared adders
	// --------------------
	assign pc_plus_imm = instruction_addr_i + immediate_i;
	assign pc_plus_4   = instruction_addr_i + branch_pkg::INSTR_BYTES;
	assign reg_target  = src1_operand_i + immediate_i;

	// class and variant decode
	// --------------------
	always_comb begin
		jump      = 1'b0;  // defaults, non control-flow classes leave all zero
		linked    = 1'b0;
		taken     = 1'b0;
		func3_bad = 1'b0;
		target    = '0;
		link      = '0;
		case (encoding_i)
			`ENCODING_JAL: begin
				jump   = 1'b1;
				linked = 1'b1;
				target = pc_plus_imm;  // pc relative
				link   = pc_plus_4;    // return address
			end
			`ENCODING_JALR: begin
				jump   = 1'b1;
				linked = 1'b1;
				target = reg_target & branch_pkg::JALR_TARGET_MASK;  // lsb forced low
				link   = pc_plus_4;
			end
			`ENCODING_BRANCH: begin
				jump = 1'b1;  // cleared again below for unknown variants
				case (func3_i)
					`RV32I_FUNC3_BRANCH_BEQ:  taken = (src1_operand_i == src2_operand_i);
					`RV32I_FUNC3_BRANCH_BNE:  taken = (src1_operand_i != src2_operand_i);
					`RV32I_FUNC3_BRANCH_BLT:  taken = ($signed(src1_operand_i) <  $signed(src2_operand_i));
					`RV32I_FUNC3_BRANCH_BGE:  taken = ($signed(src1_operand_i) >= $signed(src2_operand_i));
					`RV32I_FUNC3_BRANCH_BLTU: taken = (src1_operand_i <  src2_operand_i);
					`RV32I_FUNC3_BRANCH_BGEU: taken = (src1_operand_i >= src2_operand_i);  // isa rule
					default: begin
						jump      = 1'b0;  // not a real branch, only the func3 cause
						func3_bad = 1'b1;
					end
				endcase
				if (jump) begin
					target = taken ? pc_plus_imm : pc_plus_4;  // fall-through when not taken
				end
			end
			default: begin
				jump = 1'b0;  // no control flow
			end
		endcase
	end

	// exception vector
	// --------------------
	always_comb begin
		exc = '0;
		exc[branch_pkg::EXC_FUNC3]          = func3_bad;
		exc[branch_pkg::EXC_MISPREDICT]     = jump && (target != instruction_next_addr_i);
		exc[branch_pkg::EXC_WORD_MISALIGN]  = jump && target[1];
		exc[branch_pkg::EXC_HWORD_MISALIGN] = jump && target[0];  // never for jalr
	end

	// result to the resolve stage
	assign res.valid  = valid_i;  // straight through, stage consumes every cycle
	assign res.jump   = jump;
	assign res.linked = linked;
	assign res.target = target;
	assign res.link   = link;
	assign res.exc    = exc;
	assign res.pc     = instruction_addr_i;

	// a live jump must never hand an unknown target to the registered stage
	always_comb begin
		if (valid_i && jump) begin
			assert (!$isunknown(target))
				else $error("target_address_generator: unknown target on valid jump");
		end
	end

endmodule

//--- verif/branch_unit_tb.sv
// stops at the first mismatch; apb accesses run only while valid_i is low, 20 ns clock
`timescale 1ns/1ps
`include "rv32i_encoding.svh"

module branch_unit_tb;

	localparam int CLK_PERIOD  = 20;
	localparam int BATCH       = 400;  // instructions per batch
	localparam int BATCHES     = 6;
	localparam int WATCHDOG_NS = (BATCH * BATCHES + 600) * CLK_PERIOD;  // margin covers reset and apb

	logic                  clk_i;
	logic                  reset_i;
	logic                  valid_i;
	branch_pkg::encoding_t encoding_i;
	branch_pkg::func3_t    func3_i;
	branch_pkg::addr_t     instruction_addr_i;
	branch_pkg::addr_t     instruction_next_addr_i;
	branch_pkg::xlen_t     src1_operand_i;
	branch_pkg::xlen_t     src2_operand_i;
	branch_pkg::xlen_t     immediate_i;
	logic                  psel_i;
	logic                  penable_i;
	logic                  pwrite_i;
	branch_pkg::apb_addr_t paddr_i;
	branch_pkg::xlen_t     pwdata_i;
	branch_pkg::xlen_t     prdata_o;
	logic                  pready_o;
	logic                  pslverr_o;
	logic                  redirect_valid_o;
	branch_pkg::addr_t     redirect_addr_o;
	logic                  link_valid_o;
	branch_pkg::xlen_t     link_o;
	logic                  trap_o;
	branch_pkg::exc_t      trap_cause_o;

	logic [31:0]       rng;                            // xorshift state
	logic              m_jump, m_linked, m_bad;        // model outputs in the cycle of the inputs
	logic              m_trap, m_redirect, m_link_valid;
	branch_pkg::addr_t m_target;
	branch_pkg::xlen_t m_link;
	branch_pkg::exc_t  m_exc, m_masked;
	logic              exp_redirect, exp_link_valid, exp_trap;  // model outputs one cycle later
	branch_pkg::addr_t exp_redirect_addr, exp_trap_pc;
	branch_pkg::xlen_t exp_link;
	branch_pkg::exc_t  exp_cause;
	branch_pkg::exc_t  ctrl_model, status_model;       // register file as software sees it
	branch_pkg::xlen_t count_model;
	branch_pkg::addr_t trap_addr_model;
	logic              apb_wr;

	branch_unit_top u_branch_unit_top (.*);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	task automatic abort_run();
		$display("test failed");
		$fatal(1, "run stopped on the first error");
	endtask

	task automatic report_mismatch(input string field);
		$display("mismatch at %0d ns: %s", $time, field);
		abort_run();
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run did not reach its end within %0d ns", WATCHDOG_NS);
		abort_run();
	end

	// stimulus helpers
	// --------------------
	function automatic logic [31:0] xorshift_step();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic branch_pkg::xlen_t boundary_value(input logic [1:0] k);
		case (k)
			2'd0:    return 32'h8000_0000;  // most negative
			2'd1:    return 32'h7fff_ffff;  // most positive
			2'd2:    return 32'h0000_0000;
			default: return 32'hffff_ffff;  // -1 signed and max unsigned
		endcase
	endfunction

	// next pc of an instruction by the isa rules with the flags returned through the outputs
	function automatic branch_pkg::addr_t predict_target(
		input branch_pkg::encoding_t enc, input branch_pkg::func3_t f3,
		input branch_pkg::addr_t pc,
		input branch_pkg::xlen_t a, input branch_pkg::xlen_t b, input branch_pkg::xlen_t imm,
		output logic jump, output logic linked, output logic bad);
		logic taken;
		jump   = (enc == `ENCODING_JAL) || (enc == `ENCODING_JALR) || (enc == `ENCODING_BRANCH);
		linked = (enc == `ENCODING_JAL) || (enc == `ENCODING_JALR);
		bad    = 1'b0;
		case (f3)
			`RV32I_FUNC3_BRANCH_BEQ:  taken = (a == b);
			`RV32I_FUNC3_BRANCH_BNE:  taken = (a != b);
			`RV32I_FUNC3_BRANCH_BLT:  taken = ($signed(a) < $signed(b));
			`RV32I_FUNC3_BRANCH_BGE:  taken = ($signed(a) >= $signed(b));
			`RV32I_FUNC3_BRANCH_BLTU: taken = (a < b);
			`RV32I_FUNC3_BRANCH_BGEU: taken = (a >= b);  // unsigned greater or equal
			default: begin
				taken = 1'b0;
				bad   = (enc == `ENCODING_BRANCH);  // reserved branch variant
			end
		endcase
		if (bad) begin
			jump = 1'b0;
		end
		if (enc == `ENCODING_JAL) return pc + imm;
		if (enc == `ENCODING_JALR) return (a + imm) & ~32'd1;  // lsb dropped
		if (jump) return taken ? pc + imm : pc + 32'd4;
		return '0;
	endfunction

	// reference model
	// --------------------
	always_comb begin
		m_target = predict_target(encoding_i, func3_i, instruction_addr_i, src1_operand_i,
			src2_operand_i, immediate_i, m_jump, m_linked, m_bad);
		m_link   = m_linked ? instruction_addr_i + 32'd4 : '0;
		m_exc    = {m_bad, m_jump && (m_target != instruction_next_addr_i),
			m_jump && m_target[1], m_jump && m_target[0]};  // bits 3..0
		m_masked     = m_exc & ctrl_model;
		m_trap       = valid_i && ((m_masked & 4'b1011) != 4'b0000);  // mispredict never traps
		m_redirect   = valid_i && !m_trap && m_masked[2];
		m_link_valid = valid_i && m_linked && !m_trap;
	end

	assign apb_wr = psel_i && penable_i && pwrite_i;  // write lands at the edge ending access

	always @(posedge clk_i) begin
		branch_pkg::exc_t status_clr;
		status_clr = (apb_wr && paddr_i == branch_pkg::REG_STATUS) ? pwdata_i[3:0] : 4'b0000;
		if (reset_i) begin
			exp_redirect    <= 1'b0;
			exp_link_valid  <= 1'b0;
			exp_trap        <= 1'b0;
			exp_cause       <= 4'b0000;
			ctrl_model      <= 4'hf;  // all enables on after reset
			status_model    <= 4'h0;
			count_model     <= 32'd0;
			trap_addr_model <= 32'd0;
		end else begin
			exp_redirect      <= m_redirect;
			exp_redirect_addr <= m_target;
			exp_link_valid    <= m_link_valid;
			exp_link          <= m_link;
			exp_trap          <= m_trap;
			exp_cause         <= m_trap ? m_masked : 4'b0000;
			exp_trap_pc       <= instruction_addr_i;
			if (apb_wr && paddr_i == branch_pkg::REG_CTRL) begin
				ctrl_model <= pwdata_i[3:0];
			end
			status_model <= (status_model & ~status_clr) | (exp_trap ? exp_cause : 4'b0000);
			if (apb_wr && paddr_i == branch_pkg::REG_REDIRECT_COUNT) begin
				count_model <= 32'd0;
			end else if (exp_redirect && count_model != 32'hffff_ffff) begin
				count_model <= count_model + 32'd1;
			end
			if (exp_trap) begin
				trap_addr_model <= exp_trap_pc;  // last trap wins
			end
		end
	end

	// output checks
	// --------------------
	redirect_valid_a: assert property (@(posedge clk_i) disable iff (reset_i)
		redirect_valid_o == exp_redirect) else report_mismatch("redirect_valid_o");
	redirect_addr_a: assert property (@(posedge clk_i) disable iff (reset_i)
		exp_redirect |-> redirect_addr_o == exp_redirect_addr)
		else report_mismatch("redirect_addr_o");
	link_valid_a: assert property (@(posedge clk_i) disable iff (reset_i)
		link_valid_o == exp_link_valid) else report_mismatch("link_valid_o");
	link_a: assert property (@(posedge clk_i) disable iff (reset_i)
		exp_link_valid |-> link_o == exp_link) else report_mismatch("link_o");
	trap_a: assert property (@(posedge clk_i) disable iff (reset_i)
		trap_o == exp_trap) else report_mismatch("trap_o");
	trap_cause_a: assert property (@(posedge clk_i) disable iff (reset_i)
		trap_cause_o == exp_cause) else report_mismatch("trap_cause_o");
	pready_a: assert property (@(posedge clk_i) disable iff (reset_i)
		pready_o) else report_mismatch("pready_o");
	pslverr_idle_a: assert property (@(posedge clk_i) disable iff (reset_i)
		!(psel_i && penable_i) |-> !pslverr_o) else report_mismatch("pslverr_o outside access");
	reset_quiet_a: assert property (@(posedge clk_i)
		reset_i |=> !(redirect_valid_o || link_valid_o || trap_o || pslverr_o))
		else report_mismatch("control output after reset");

	// bus and instruction tasks, all entered 2 ns after a rising edge
	// --------------------
	task automatic apb_write(input branch_pkg::apb_addr_t addr, input branch_pkg::xlen_t data);
		psel_i   = 1'b1;  // setup phase
		pwrite_i = 1'b1;
		paddr_i  = addr;
		pwdata_i = data;
		@(posedge clk_i);
		#2;
		penable_i = 1'b1;  // access phase
		@(posedge clk_i);
		#2;
		psel_i    = 1'b0;
		penable_i = 1'b0;
		pwrite_i  = 1'b0;
	endtask

	task automatic apb_read_check(input branch_pkg::apb_addr_t addr, input branch_pkg::xlen_t data,
		input logic err, input string field);
		psel_i   = 1'b1;
		pwrite_i = 1'b0;
		paddr_i  = addr;
		@(posedge clk_i);
		#2;
		penable_i = 1'b1;
		#(CLK_PERIOD / 2);  // middle of the access phase
		assert (pslverr_o == err) else report_mismatch({field, " pslverr_o"});
		assert (err || prdata_o == data) else report_mismatch({field, " prdata_o"});
		@(posedge clk_i);
		#2;
		psel_i    = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic check_registers();
		apb_read_check(branch_pkg::REG_CTRL, {28'd0, ctrl_model}, 1'b0, "CTRL");
		apb_read_check(branch_pkg::REG_STATUS, {28'd0, status_model}, 1'b0, "STATUS");
		apb_read_check(branch_pkg::REG_REDIRECT_COUNT, count_model, 1'b0, "REDIRECT_COUNT");
		apb_read_check(branch_pkg::REG_TRAP_ADDR, trap_addr_model, 1'b0, "TRAP_ADDR");
		apb_read_check(8'h10, 32'd0, 1'b1, "unmapped offset");
	endtask

	task automatic run_instructions(input int count);
		logic [31:0]       r_ctl;
		logic [31:0]       r_a;
		logic [31:0]       r_b;
		logic [31:0]       r_imm;
		branch_pkg::addr_t t;
		logic              j, l, bad;
		repeat (count) begin
			r_ctl = xorshift_step();
			r_a   = xorshift_step();
			r_b   = xorshift_step();
			r_imm = xorshift_step();
			case (r_ctl[2:0])
				3'd0:    encoding_i = `ENCODING_JAL;
				3'd1:    encoding_i = `ENCODING_JALR;
				3'd6:    encoding_i = `ENCODING_OP;    // no control flow
				3'd7:    encoding_i = `ENCODING_LOAD;
				default: encoding_i = `ENCODING_BRANCH;
			endcase
			func3_i        = r_ctl[5:3];  // 010 and 011 unknown
			src1_operand_i = r_a;
			src2_operand_i = r_b;
			if (r_ctl[7:6] == 2'd0) begin
				src2_operand_i = r_a;  // equal
			end else if (r_ctl[7:6] == 2'd1) begin
				src1_operand_i = boundary_value(r_a[1:0]);
				src2_operand_i = boundary_value(r_b[1:0]);
			end
			immediate_i        = {{19{r_imm[12]}}, r_imm[12:0]};
			instruction_addr_i = {14'd0, r_ctl[31:16], 2'b00};
			if (r_ctl[9:8] != 2'd0) begin  // three in four aligned
				immediate_i[1:0] = 2'b00;
				if (encoding_i == `ENCODING_JALR) begin
					src1_operand_i[1:0] = 2'b00;
				end
			end
			t = predict_target(encoding_i, func3_i, instruction_addr_i, src1_operand_i,
				src2_operand_i, immediate_i, j, l, bad);
			instruction_next_addr_i = r_ctl[10] ? t : t + 32'd4 + {26'd0, r_imm[17:14], 2'b00};
			valid_i = 1'b1;
			@(posedge clk_i);
			#2;
		end
		valid_i = 1'b0;
		repeat (3) @(posedge clk_i);  // let the last pulses reach the counters
		#2;
	endtask

	// sequence
	// --------------------
	initial begin
		rng                     = 32'hbaec_4799;
		reset_i                 = 1'b1;
		valid_i                 = 1'b0;
		encoding_i              = '0;
		func3_i                 = '0;
		instruction_addr_i      = '0;
		instruction_next_addr_i = '0;
		src1_operand_i          = '0;
		src2_operand_i          = '0;
		immediate_i             = '0;
		psel_i                  = 1'b0;
		penable_i               = 1'b0;
		pwrite_i                = 1'b0;
		paddr_i                 = '0;
		pwdata_i                = '0;
		repeat (16) @(posedge clk_i);
		#2;
		reset_i = 1'b0;
		check_registers();  // reset values
		run_instructions(BATCH);
		check_registers();
		apb_write(branch_pkg::REG_STATUS, 32'h0000_0005);  // partial clear
		apb_write(branch_pkg::REG_TRAP_ADDR, 32'hdead_0000);  // read-only so the write is ignored
		apb_write(branch_pkg::REG_CTRL, 32'h0000_0004);  // redirects only
		check_registers();
		run_instructions(BATCH);
		check_registers();
		apb_write(branch_pkg::REG_CTRL, 32'h0000_000b);  // traps only
		run_instructions(BATCH);
		check_registers();
		apb_write(branch_pkg::REG_CTRL, 32'h0000_0000);
		run_instructions(BATCH);
		check_registers();
		apb_write(branch_pkg::REG_REDIRECT_COUNT, 32'h1234_5678);  // any write clears
		apb_write(branch_pkg::REG_STATUS, 32'hffff_ffff);
		apb_write(branch_pkg::REG_CTRL, 32'hffff_fff3);  // misalign only with upper bits dropped
		check_registers();
		run_instructions(BATCH);
		check_registers();
		apb_write(branch_pkg::REG_CTRL, 32'h0000_000f);
		run_instructions(BATCH);
		check_registers();
		$display("test passed");
		$finish;
	end

endmodule
